// ==== rtl/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// data path and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_AW 5

// byte lanes per word, one write enable each
`define BYTE_LANES 4

// jal writes its return address here
`define LINK_REG 31

`endif

// ==== rtl/isa_pkg.sv ====
`include "decode_settings.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_AW-1:0]     reg_addr_t;
    typedef logic [`BYTE_LANES-1:0] byte_en_t;
    typedef logic [31:0]            inst_t;
    typedef logic [25:0]            jidx_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // rt field selects the regimm branch
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR,  ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BLTZ, BR_JUMP_ABS, BR_JUMP_REG
    } branch_kind_e;

endpackage

// ==== rtl/pipe_pkg.sv ====
`include "decode_settings.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } fetch_bus_t;

    // what a later stage is about to write back
    typedef struct packed {
        logic      is_load;
        byte_en_t  byte_en;
        reg_addr_t waddr;
        word_t     wdata;
    } stage_result_t;

    typedef struct packed {
        byte_en_t  byte_en;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         src1_is_sa;
        logic         src1_is_pc;
        logic         src2_is_imm;
        logic         src2_is_8;
        byte_en_t     gr_we;
        logic         mem_we;
        logic         load;
        reg_addr_t    dest;
        word_t        imm;
        logic         uses_rs;
        logic         uses_rt;
        branch_kind_e branch_kind;
        jidx_t        jidx;
    } decode_ctrl_t;

    // execute stage sees only the datapath controls
    typedef struct packed {
        word_t     pc;
        inst_t     inst;
        alu_op_e   alu_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_8;
        byte_en_t  gr_we;
        logic      mem_we;
        logic      load;
        reg_addr_t dest;
        word_t     imm;
        word_t     rs_value;
        word_t     rt_value;
    } exec_bus_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_bus_t;

endpackage

// ==== rtl/decode_latch.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module decode_latch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_valid,
    input  fetch_bus_t fs_bus,
    input  logic       es_allowin,
    input  logic       stall,
    output logic       ds_allowin,
    output logic       ds_valid,
    output logic       ds_to_es_valid,
    output fetch_bus_t ds_bus
);

    logic ready_go;

    assign ready_go       = ~stall;
    assign ds_allowin     = ~ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus <= fs_bus;
        end
    end

endmodule

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_t        inst,
    output decode_ctrl_t ctrl
);

    opcode_e   op;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t sa;
    alu_op_e   r_op;
    logic      r_known;
    logic      r_shift;

    assign op    = opcode_e'(inst[31:26]);
    assign funct = funct_e'(inst[5:0]);
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];

    // R-type function code to ALU op
    always_comb begin
        r_op    = ALU_ADD;
        r_known = 1'b1;
        r_shift = 1'b0;
        case (funct)
            FN_ADDU: r_op = ALU_ADD;
            FN_SUBU: r_op = ALU_SUB;
            FN_SLT:  r_op = ALU_SLT;
            FN_SLTU: r_op = ALU_SLTU;
            FN_AND:  r_op = ALU_AND;
            FN_OR:   r_op = ALU_OR;
            FN_XOR:  r_op = ALU_XOR;
            FN_NOR:  r_op = ALU_NOR;
            FN_SLL: begin
                r_op    = ALU_SLL;
                r_shift = 1'b1;
            end
            FN_SRL: begin
                r_op    = ALU_SRL;
                r_shift = 1'b1;
            end
            FN_SRA: begin
                r_op    = ALU_SRA;
                r_shift = 1'b1;
            end
            default: r_known = 1'b0;
        endcase
    end

    always_comb begin
        ctrl      = '0;
        ctrl.dest = rd;
        ctrl.jidx = inst[25:0];
        case (op)
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    if (rt == '0 && rd == '0 && sa == '0) begin
                        ctrl.uses_rs     = 1'b1;
                        ctrl.branch_kind = BR_JUMP_REG;
                    end
                end else if (r_known && r_shift) begin
                    // shift amount comes from sa, rs must be zero
                    if (rs == '0) begin
                        ctrl.alu_op     = r_op;
                        ctrl.src1_is_sa = 1'b1;
                        ctrl.uses_rt    = 1'b1;
                        ctrl.gr_we      = '1;
                    end
                end else if (r_known && sa == '0) begin
                    ctrl.alu_op  = r_op;
                    ctrl.uses_rs = 1'b1;
                    ctrl.uses_rt = 1'b1;
                    ctrl.gr_we   = '1;
                end
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.alu_op      = (op == OP_ANDI) ? ALU_AND :
                                   (op == OP_ORI)  ? ALU_OR  :
                                   (op == OP_XORI) ? ALU_XOR : ALU_ADD;
                ctrl.src2_is_imm = 1'b1;
                ctrl.uses_rs     = 1'b1;
                ctrl.gr_we       = '1;
                ctrl.dest        = rt;
            end
            OP_LUI: begin
                if (rs == '0) begin
                    ctrl.alu_op      = ALU_LUI;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.gr_we       = '1;
                    ctrl.dest        = rt;
                end
            end
            OP_LW: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.uses_rs     = 1'b1;
                ctrl.load        = 1'b1;
                ctrl.gr_we       = '1;
                ctrl.dest        = rt;
            end
            OP_SW: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.uses_rs     = 1'b1;
                ctrl.uses_rt     = 1'b1;
                ctrl.mem_we      = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.uses_rs     = 1'b1;
                ctrl.uses_rt     = 1'b1;
                ctrl.branch_kind = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_REGIMM: begin
                if (rt == RT_BLTZ || rt == RT_BGEZ) begin
                    ctrl.uses_rs     = 1'b1;
                    ctrl.branch_kind = (rt == RT_BGEZ) ? BR_BGEZ : BR_BLTZ;
                end
            end
            OP_J: ctrl.branch_kind = BR_JUMP_ABS;
            OP_JAL: begin
                // link value pc + 8 is formed in execute
                ctrl.branch_kind = BR_JUMP_ABS;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_8   = 1'b1;
                ctrl.gr_we       = '1;
                ctrl.dest        = reg_addr_t'(`LINK_REG);
            end
            default: ;
        endcase
        if (op == OP_ANDI || op == OP_ORI || op == OP_XORI) begin
            ctrl.imm = {{(`XLEN-16){1'b0}}, inst[15:0]};
        end else begin
            ctrl.imm = {{(`XLEN-16){inst[15]}}, inst[15:0]};
        end
    end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr [2],
    output word_t     rdata [2],
    input  rf_write_t wr
);

    localparam int LANE_W = `XLEN / `BYTE_LANES;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        for (int b = 0; b < `BYTE_LANES; b++) begin
            if (wr.byte_en[b]) begin
                regs[wr.waddr][b*LANE_W +: LANE_W] <= wr.wdata[b*LANE_W +: LANE_W];
            end
        end
    end

    // r0 is hardwired, whatever was written there
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
        end
    end

endmodule

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module operand_bypass
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  reg_addr_t     raddr,
    input  logic          used,
    input  logic          ds_valid,
    input  word_t         rf_data,
    input  stage_result_t es_res,
    input  stage_result_t ms_res,
    input  stage_result_t ws_res,
    output word_t         value,
    output logic          load_hazard
);

    localparam int LANE_W = `XLEN / `BYTE_LANES;

    logic es_hit;
    logic ms_hit;
    logic ws_hit;

    // r0 never matches a producer
    assign es_hit = (raddr != '0) && (es_res.waddr == raddr);
    assign ms_hit = (raddr != '0) && (ms_res.waddr == raddr);
    assign ws_hit = (raddr != '0) && (ws_res.waddr == raddr);

    // youngest producer wins, lane by lane
    always_comb begin
        for (int b = 0; b < `BYTE_LANES; b++) begin
            if (es_hit && es_res.byte_en[b]) begin
                value[b*LANE_W +: LANE_W] = es_res.wdata[b*LANE_W +: LANE_W];
            end else if (ms_hit && ms_res.byte_en[b]) begin
                value[b*LANE_W +: LANE_W] = ms_res.wdata[b*LANE_W +: LANE_W];
            end else if (ws_hit && ws_res.byte_en[b]) begin
                value[b*LANE_W +: LANE_W] = ws_res.wdata[b*LANE_W +: LANE_W];
            end else begin
                value[b*LANE_W +: LANE_W] = rf_data[b*LANE_W +: LANE_W];
            end
        end
    end

    // load data not available until memory stage
    assign load_hazard = ds_valid && used && es_res.is_load && es_hit;

endmodule

// ==== rtl/branch_resolver.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module branch_resolver
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         ds_valid,
    input  logic         ready,
    input  word_t        pc,
    input  decode_ctrl_t ctrl,
    input  word_t        rs_value,
    input  word_t        rt_value,
    output branch_bus_t  br
);

    word_t pc_plus4;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  cond;

    assign pc_plus4 = pc + word_t'(4);
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[`XLEN-1];

    always_comb begin
        case (ctrl.branch_kind)
            BR_BEQ:      cond = rs_eq_rt;
            BR_BNE:      cond = ~rs_eq_rt;
            BR_BGEZ:     cond = ~rs_neg;
            BR_BLTZ:     cond = rs_neg;
            BR_JUMP_ABS: cond = 1'b1;
            BR_JUMP_REG: cond = 1'b1;
            default:     cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.branch_kind)
            BR_JUMP_ABS: br.target = {pc_plus4[`XLEN-1:`XLEN-4], ctrl.jidx, 2'b00};
            BR_JUMP_REG: br.target = rs_value;
            // conditional branches are pc relative
            default:     br.target = pc_plus4 + {ctrl.imm[`XLEN-3:0], 2'b00};
        endcase
    end

    // a stalled or empty stage must not redirect fetch
    assign br.taken = cond && ds_valid && ready;

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          fs_valid,
    input  fetch_bus_t    fs_bus,
    output logic          ds_allowin,
    input  logic          es_allowin,
    output logic          ds_to_es_valid,
    output exec_bus_t     ds_to_es_bus,
    input  stage_result_t es_res,
    input  stage_result_t ms_res,
    input  stage_result_t ws_res,
    input  rf_write_t     ws_to_rf,
    output branch_bus_t   br_bus
);

    logic         ds_valid;
    fetch_bus_t   ds_bus;
    decode_ctrl_t ctrl;
    logic         stall;
    logic         ds_ready_go;
    reg_addr_t    rf_raddr  [2];
    word_t        rf_rdata  [2];
    logic         src_used  [2];
    word_t        src_value [2];
    logic         src_hazard[2];

    decode_latch u_decode_latch (
        .clk           (clk),
        .reset         (reset),
        .fs_valid      (fs_valid),
        .fs_bus        (fs_bus),
        .es_allowin    (es_allowin),
        .stall         (stall),
        .ds_allowin    (ds_allowin),
        .ds_valid      (ds_valid),
        .ds_to_es_valid(ds_to_es_valid),
        .ds_bus        (ds_bus)
    );

    inst_decoder u_inst_decoder (
        .inst(ds_bus.inst),
        .ctrl(ctrl)
    );

    // port 0 reads rs, port 1 reads rt
    assign rf_raddr[0] = ds_bus.inst[25:21];
    assign rf_raddr[1] = ds_bus.inst[20:16];
    assign src_used[0] = ctrl.uses_rs;
    assign src_used[1] = ctrl.uses_rt;

    regfile u_regfile (
        .clk  (clk),
        .raddr(rf_raddr),
        .rdata(rf_rdata),
        .wr   (ws_to_rf)
    );

    for (genvar i = 0; i < 2; i++) begin : g_bypass
        operand_bypass u_operand_bypass (
            .raddr      (rf_raddr[i]),
            .used       (src_used[i]),
            .ds_valid   (ds_valid),
            .rf_data    (rf_rdata[i]),
            .es_res     (es_res),
            .ms_res     (ms_res),
            .ws_res     (ws_res),
            .value      (src_value[i]),
            .load_hazard(src_hazard[i])
        );
    end

    assign stall       = src_hazard[0] | src_hazard[1];
    assign ds_ready_go = ~stall;

    branch_resolver u_branch_resolver (
        .ds_valid(ds_valid),
        .ready   (ds_ready_go),
        .pc      (ds_bus.pc),
        .ctrl    (ctrl),
        .rs_value(src_value[0]),
        .rt_value(src_value[1]),
        .br      (br_bus)
    );

    always_comb begin
        ds_to_es_bus.pc          = ds_bus.pc;
        ds_to_es_bus.inst        = ds_bus.inst;
        ds_to_es_bus.alu_op      = ctrl.alu_op;
        ds_to_es_bus.src1_is_sa  = ctrl.src1_is_sa;
        ds_to_es_bus.src1_is_pc  = ctrl.src1_is_pc;
        ds_to_es_bus.src2_is_imm = ctrl.src2_is_imm;
        ds_to_es_bus.src2_is_8   = ctrl.src2_is_8;
        ds_to_es_bus.gr_we       = ctrl.gr_we;
        ds_to_es_bus.mem_we      = ctrl.mem_we;
        ds_to_es_bus.load        = ctrl.load;
        ds_to_es_bus.dest        = ctrl.dest;
        ds_to_es_bus.imm         = ctrl.imm;
        ds_to_es_bus.rs_value    = src_value[0];
        ds_to_es_bus.rt_value    = src_value[1];
    end

endmodule

// ==== test/decode_properties.sv ====
`timescale 1ns/10ps

module decode_properties
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic          ds_to_es_valid,
    input exec_bus_t     ds_to_es_bus,
    input logic          es_allowin,
    input stage_result_t es_res,
    input decode_ctrl_t  ctrl,
    input branch_bus_t   br_bus
);

    int   fails = 0;
    logic load_use;

    // a load in execute to a source the held instruction reads
    assign load_use = es_res.is_load && es_res.waddr != '0 &&
                      ((ctrl.uses_rs && es_res.waddr == ds_to_es_bus.inst[25:21]) ||
                       (ctrl.uses_rt && es_res.waddr == ds_to_es_bus.inst[20:16]));

    a_idle_after_reset: assert property (@(posedge clk) reset |=> !ds_to_es_valid)
        else begin
            $error("valid output right after reset");
            fails++;
        end

    a_no_valid_on_hazard: assert property (@(posedge clk) disable iff (reset)
        load_use |-> !ds_to_es_valid)
        else begin
            $error("valid output while a load-use hazard is flagged");
            fails++;
        end

    // held item must not move while execute refuses it
    a_hold_on_backpressure: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |=> $stable(ds_to_es_bus))
        else begin
            $error("output bus changed under back-pressure");
            fails++;
        end

    a_taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        br_bus.taken |-> ds_to_es_valid)
        else begin
            $error("branch taken without a valid item");
            fails++;
        end

endmodule

bind decode_stage decode_properties u_decode_properties (
    .clk           (clk),
    .reset         (reset),
    .ds_to_es_valid(ds_to_es_valid),
    .ds_to_es_bus  (ds_to_es_bus),
    .es_allowin    (es_allowin),
    .es_res        (es_res),
    .ctrl          (ctrl),
    .br_bus        (br_bus)
);

// ==== test/tb_decode_stage.sv ====
`timescale 1ns/10ps

`include "decode_settings.svh"

module tb_decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int N_ITEMS = 300;

    typedef struct packed {
        exec_bus_t   ex;
        branch_bus_t br;
        logic        stall;
    } expect_t;

    logic          clk;
    logic          reset;
    logic          fs_valid;
    fetch_bus_t    fs_bus;
    logic          ds_allowin;
    logic          es_allowin;
    logic          ds_to_es_valid;
    exec_bus_t     ds_to_es_bus;
    stage_result_t es_res;
    stage_result_t ms_res;
    stage_result_t ws_res;
    rf_write_t     ws_to_rf;
    branch_bus_t   br_bus;

    integer     seed;
    int         errors;
    word_t      mregs [32];
    fetch_bus_t held;
    logic       hv;
    expect_t    exp_r;
    logic       exp_allowin;

    decode_stage u_decode_stage (
        .clk           (clk),
        .reset         (reset),
        .fs_valid      (fs_valid),
        .fs_bus        (fs_bus),
        .ds_allowin    (ds_allowin),
        .es_allowin    (es_allowin),
        .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es_bus  (ds_to_es_bus),
        .es_res        (es_res),
        .ms_res        (ms_res),
        .ws_res        (ws_res),
        .ws_to_rf      (ws_to_rf),
        .br_bus        (br_bus)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [255:0] act,
                               input logic [255:0] exp);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // youngest producer first, lane by lane, r0 never forwarded
    function automatic word_t forward_operand(input reg_addr_t a, input word_t rf,
                                              input stage_result_t es, ms, ws);
        word_t v;
        v = (a == 0) ? '0 : rf;
        for (int b = 3; b >= 0; b--) begin
            if (a != 0 && ws.waddr == a && ws.byte_en[b]) v[8*b +: 8] = ws.wdata[8*b +: 8];
            if (a != 0 && ms.waddr == a && ms.byte_en[b]) v[8*b +: 8] = ms.wdata[8*b +: 8];
            if (a != 0 && es.waddr == a && es.byte_en[b]) v[8*b +: 8] = es.wdata[8*b +: 8];
        end
        return v;
    endfunction

    function automatic expect_t predict(input fetch_bus_t f, input logic valid,
                                        input word_t regs [32],
                                        input stage_result_t es, ms, ws);
        expect_t      x;
        logic [5:0]   op;
        logic [5:0]   fn;
        reg_addr_t    rs;
        reg_addr_t    rt;
        reg_addr_t    rd;
        reg_addr_t    sa;
        branch_kind_e bk;
        logic         urs;
        logic         urt;
        logic         cond;
        word_t        pc4;
        x  = '0;
        op = f.inst[31:26];
        fn = f.inst[5:0];
        rs = f.inst[25:21];
        rt = f.inst[20:16];
        rd = f.inst[15:11];
        sa = f.inst[10:6];
        bk = BR_NONE;
        urs = 1'b0;
        urt = 1'b0;
        x.ex.pc   = f.pc;
        x.ex.inst = f.inst;
        x.ex.dest = rd;
        if (op == 6'h0c || op == 6'h0d || op == 6'h0e) x.ex.imm = {16'h0, f.inst[15:0]};
        else x.ex.imm = {{16{f.inst[15]}}, f.inst[15:0]};
        case (op)
            6'h00: begin
                if (fn == 6'h08) begin
                    if (rt == 0 && rd == 0 && sa == 0) begin
                        urs = 1'b1;
                        bk  = BR_JUMP_REG;
                    end
                end else if (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) begin
                    if (rs == 0) begin
                        x.ex.alu_op = (fn == 6'h00) ? ALU_SLL : (fn == 6'h02) ? ALU_SRL : ALU_SRA;
                        x.ex.src1_is_sa = 1'b1;
                        x.ex.gr_we = 4'hf;
                        urt = 1'b1;
                    end
                end else if (sa == 0) begin
                    x.ex.gr_we = 4'hf;
                    urs = 1'b1;
                    urt = 1'b1;
                    case (fn)
                        6'h21: x.ex.alu_op = ALU_ADD;
                        6'h23: x.ex.alu_op = ALU_SUB;
                        6'h2a: x.ex.alu_op = ALU_SLT;
                        6'h2b: x.ex.alu_op = ALU_SLTU;
                        6'h24: x.ex.alu_op = ALU_AND;
                        6'h25: x.ex.alu_op = ALU_OR;
                        6'h26: x.ex.alu_op = ALU_XOR;
                        6'h27: x.ex.alu_op = ALU_NOR;
                        default: begin
                            x.ex.gr_we = 4'h0;
                            urs = 1'b0;
                            urt = 1'b0;
                        end
                    endcase
                end
            end
            6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h23: begin
                x.ex.alu_op = (op == 6'h0c) ? ALU_AND : (op == 6'h0d) ? ALU_OR :
                              (op == 6'h0e) ? ALU_XOR : ALU_ADD;
                x.ex.src2_is_imm = 1'b1;
                x.ex.gr_we = 4'hf;
                x.ex.dest  = rt;
                x.ex.load  = (op == 6'h23);
                urs = 1'b1;
            end
            6'h0f: begin
                if (rs == 0) begin
                    x.ex.alu_op = ALU_LUI;
                    x.ex.src2_is_imm = 1'b1;
                    x.ex.gr_we = 4'hf;
                    x.ex.dest  = rt;
                end
            end
            6'h2b: begin
                x.ex.src2_is_imm = 1'b1;
                x.ex.mem_we = 1'b1;
                urs = 1'b1;
                urt = 1'b1;
            end
            6'h04, 6'h05: begin
                urs = 1'b1;
                urt = 1'b1;
                bk  = (op == 6'h04) ? BR_BEQ : BR_BNE;
            end
            6'h01: begin
                if (rt == 0 || rt == 1) begin
                    urs = 1'b1;
                    bk  = (rt == 1) ? BR_BGEZ : BR_BLTZ;
                end
            end
            6'h02: bk = BR_JUMP_ABS;
            6'h03: begin
                bk = BR_JUMP_ABS;
                x.ex.src1_is_pc = 1'b1;
                x.ex.src2_is_8  = 1'b1;
                x.ex.gr_we = 4'hf;
                x.ex.dest  = 5'd31;
            end
            default: ;
        endcase
        x.ex.rs_value = forward_operand(rs, regs[rs], es, ms, ws);
        x.ex.rt_value = forward_operand(rt, regs[rt], es, ms, ws);
        x.stall = valid && es.is_load && ((urs && rs != 0 && es.waddr == rs) ||
                                          (urt && rt != 0 && es.waddr == rt));
        pc4 = f.pc + 32'd4;
        case (bk)
            BR_BEQ:  cond = (x.ex.rs_value == x.ex.rt_value);
            BR_BNE:  cond = (x.ex.rs_value != x.ex.rt_value);
            BR_BGEZ: cond = !x.ex.rs_value[31];
            BR_BLTZ: cond = x.ex.rs_value[31];
            BR_JUMP_ABS, BR_JUMP_REG: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        if (bk == BR_JUMP_ABS) x.br.target = {pc4[31:28], f.inst[25:0], 2'b00};
        else if (bk == BR_JUMP_REG) x.br.target = x.ex.rs_value;
        else x.br.target = pc4 + {{14{f.inst[15]}}, f.inst[15:0], 2'b00};
        x.br.taken = valid && !x.stall && cond;
        return x;
    endfunction

    // compare on the falling edge, then step the model to the next rising edge
    always @(negedge clk) begin
        if (u_decode_stage.u_decode_properties.fails != 0) begin
            $display("A bound assertion failed before %0t ns", $time);
            $display("Checks failed");
            $fatal(1, "assertion failure");
        end
        if (reset) begin
            hv = 1'b0;
        end else begin
            exp_r = predict(held, hv, mregs, es_res, ms_res, ws_res);
            exp_allowin = !hv || (!exp_r.stall && es_allowin);
            check_value("ds_to_es_valid", ds_to_es_valid, hv && !exp_r.stall);
            check_value("ds_allowin", ds_allowin, exp_allowin);
            check_value("br_bus.taken", br_bus.taken, exp_r.br.taken);
            if (exp_r.br.taken) check_value("br_bus.target", br_bus.target, exp_r.br.target);
            if (hv && !exp_r.stall) check_value("ds_to_es_bus", ds_to_es_bus, exp_r.ex);
            if (exp_allowin) begin
                hv = fs_valid;
                if (fs_valid) held = fs_bus;
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (ws_to_rf.byte_en[b]) mregs[ws_to_rf.waddr][8*b +: 8] = ws_to_rf.wdata[8*b +: 8];
        end
    end

    initial begin
        #(N_ITEMS * 20 * 100);
        $display("Watchdog timeout: the test did not finish in time");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    task automatic drive_cycle(input logic v, input fetch_bus_t f, input stage_result_t e,
                               input stage_result_t m, input stage_result_t w,
                               input rf_write_t wr, input logic ea);
        @(posedge clk);
        fs_valid   <= v;
        fs_bus     <= f;
        es_res     <= e;
        ms_res     <= m;
        ws_res     <= w;
        ws_to_rf   <= wr;
        es_allowin <= ea;
    endtask

    // hold the inputs until the stage accepts at the next edge
    task automatic issue(input logic v, input fetch_bus_t f, input stage_result_t e,
                         input stage_result_t m, input stage_result_t w, input rf_write_t wr);
        drive_cycle(v, f, e, m, w, wr, 1'b1);
        @(negedge clk);
        while (!ds_allowin) begin
            @(negedge clk);
        end
    endtask

    task automatic make_item(input int kind, input logic [4:0] mask, output fetch_bus_t f);
        logic [31:0] r;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [5:0]  rfn [11];
        logic [5:0]  iop [7];
        rfn = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27, 6'h00, 6'h02, 6'h03};
        iop = '{6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b};
        r  = $random(seed);
        ra = r[31:27] & mask;
        rb = r[26:22] & mask;
        rc = r[21:17] & mask;
        f.pc = $random(seed) & 32'hffff_fffc;
        if (kind < 8) f.inst = {6'h00, ra, rb, rc, 5'd0, rfn[kind]};
        else if (kind < 11) f.inst = {6'h00, 5'd0, rb, rc, r[10:6], rfn[kind]};
        else if (kind < 18) f.inst = {iop[kind-11], (kind == 15) ? 5'd0 : ra, rb, r[15:0]};
        else if (kind < 20) f.inst = {(kind == 18) ? 6'h04 : 6'h05, ra, rb, r[15:0]};
        else if (kind < 22) f.inst = {6'h01, ra, (kind == 20) ? 5'd1 : 5'd0, r[15:0]};
        else if (kind < 24) f.inst = {(kind == 22) ? 6'h02 : 6'h03, r[25:0]};
        else if (kind == 24) f.inst = {6'h00, ra, 15'd0, 6'h08};
        else f.inst = $random(seed);
    endtask

    task automatic make_result(input logic [4:0] mask, output stage_result_t s);
        s.is_load = 1'b0;
        s.byte_en = $random(seed);
        s.waddr   = $random(seed) & mask;
        s.wdata   = $random(seed);
    endtask

    initial begin
        stage_result_t idle;
        stage_result_t e;
        stage_result_t m;
        stage_result_t w;
        stage_result_t load_r1;
        rf_write_t     wr;
        rf_write_t     no_wr;
        fetch_bus_t    f;
        fetch_bus_t    g;
        seed = 76353;
        errors = 0;
        idle = '0;
        no_wr = '0;
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_bus = '0;
        es_allowin = 1'b1;
        es_res = '0;
        ms_res = '0;
        ws_res = '0;
        ws_to_rf = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_value("br_bus.taken", br_bus.taken, 1'b0);
        // fill every register, r0 included
        for (int r = 0; r < 32; r++) begin
            wr.byte_en = 4'hf;
            wr.waddr   = r[4:0];
            wr.wdata   = $random(seed);
            issue(1'b0, '0, idle, idle, idle, wr);
        end
        repeat (60) begin
            make_item({$random(seed)} % 26, 5'h1f, f);
            issue(1'b1, f, idle, idle, idle, no_wr);
        end
        // partial writes mixed with reads
        repeat (40) begin
            make_item({$random(seed)} % 25, 5'h07, f);
            wr.byte_en = $random(seed);
            wr.waddr   = $random(seed) & 5'h07;
            wr.wdata   = $random(seed);
            issue(1'b1, f, idle, idle, idle, wr);
        end
        // overlapping producers on few registers
        repeat (60) begin
            make_item({$random(seed)} % 25, 5'h03, f);
            make_result(5'h03, e);
            make_result(5'h03, m);
            make_result(5'h03, w);
            issue(1'b1, f, e, m, w, no_wr);
        end
        // load-use stall on rs of addu r3, r1, r2
        f.pc = 32'h0000_1000;
        f.inst = {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21};
        issue(1'b1, f, idle, idle, idle, no_wr);
        load_r1 = '0;
        load_r1.is_load = 1'b1;
        load_r1.byte_en = 4'hf;
        load_r1.waddr = 5'd1;
        load_r1.wdata = $random(seed);
        make_item(12, 5'h1f, g);
        repeat (4) begin
            drive_cycle(1'b1, g, load_r1, idle, idle, no_wr, 1'b1);
            @(negedge clk);
            check_value("ds_to_es_valid", ds_to_es_valid, 1'b0);
            check_value("ds_allowin", ds_allowin, 1'b0);
        end
        drive_cycle(1'b1, g, idle, idle, idle, no_wr, 1'b1);
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 1'b1);
        // execute back-pressure on the next item
        make_item(0, 5'h1f, f);
        repeat (3) begin
            drive_cycle(1'b1, f, idle, idle, idle, no_wr, 1'b0);
            @(negedge clk);
            check_value("ds_allowin", ds_allowin, 1'b0);
        end
        issue(1'b1, f, idle, idle, idle, no_wr);
        repeat (60) begin
            make_item(18 + {$random(seed)} % 7, 5'h03, f);
            issue(1'b1, f, idle, idle, idle, no_wr);
        end
        repeat (3) issue(1'b0, '0, idle, idle, idle, no_wr);
        @(negedge clk);
        if (errors == 0 && u_decode_stage.u_decode_properties.fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/decode_latch.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_bypass.sv
rtl/branch_resolver.sv
rtl/decode_stage.sv
test/decode_properties.sv
test/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/pipe_pkg.sv
      - rtl/decode_latch.sv
      - rtl/inst_decoder.sv
      - rtl/regfile.sv
      - rtl/operand_bypass.sv
      - rtl/branch_resolver.sv
      - rtl/decode_stage.sv
  - target: test
    files:
      - test/decode_properties.sv
      - test/tb_decode_stage.sv
